// File: verilog/i2c_master_params.svh
`ifndef I2C_MASTER_PARAMS_SVH
`define I2C_MASTER_PARAMS_SVH

// Width of the protocol state encoding
`define I2C_STATE_W     4

// SCL rising edges in one address or data byte
`define I2C_BYTE_BITS   8

// Bit index loaded whenever no byte is on the wire, MSB goes first
`define I2C_FIRST_BIT   7

`endif

// File: verilog/i2c_bus_pkg.sv
`include "i2c_master_params.svh"

package i2c_bus_pkg;

    // Protocol phases of the master, one per bus activity
    typedef enum logic [`I2C_STATE_W-1:0] {
        IDLE           = 4'd0,
        START          = 4'd1,
        ADDRESS        = 4'd2,  // Slave address plus R/W bit
        READ_ACK       = 4'd3,  // Slave ACK after address
        WRITE_DATA     = 4'd4,
        READ_LATER_ACK = 4'd5,  // Slave ACK after a written byte
        READ_DATA      = 4'd6,
        WRITE_ACK      = 4'd7,  // Master ACK/NACK after a read byte
        REPEAT_START   = 4'd8,
        STOP           = 4'd9
    } i2c_state_e;

endpackage

// File: verilog/i2c_ctrl_pkg.sv
package i2c_ctrl_pkg;

    // Line controls sent to the datapath and the SCL generator
    typedef struct packed {
        logic sda_low_en;       // Pull SDA down
        logic clk_en;           // Run the SCL generator
        logic write_data_en;    // Shift a data bit onto SDA
        logic write_addr_en;    // Shift an address bit onto SDA
        logic receive_data_en;  // Sample SDA into the RX shifter
        logic sda_en;           // Master owns SDA
        logic scl_en;           // Master owns SCL
    } line_ctrl_t;

endpackage

// File: verilog/i2c_phase_if.sv
`timescale 1ns/100ps

interface i2c_phase_if;
    import i2c_bus_pkg::*;

    i2c_state_e state;          // Current protocol phase
    i2c_state_e next_state;
    logic       scl_rise;       // One-cycle pulses
    logic       scl_fall;
    logic       byte_done;      // All bits of the byte clocked
    logic       ack_to_read;    // ACK seen, continue with a read
    logic       ack_to_write;   // ACK seen, continue with a write

    // Decode stage
    modport monitor (
        input  state,
        output scl_rise, scl_fall, byte_done, ack_to_read, ack_to_write
    );

    // Execute stage
    modport sequencer (
        output state, next_state,
        input  scl_rise, scl_fall, byte_done, ack_to_read, ack_to_write
    );

    // Result stage
    modport driver (
        input state, next_state, scl_rise, scl_fall, byte_done, ack_to_read, ack_to_write
    );

endinterface

// File: verilog/i2c_bus_monitor.sv
`timescale 1ns/100ps
`include "i2c_master_params.svh"

module i2c_bus_monitor (
    input  logic  i2c_core_clk_i,
    input  logic  reset_ni,
    input  logic  i2c_scl_i,
    input  logic  i2c_sda_i,
    input  logic  rw_i,         // 1 read, 0 write
    input  logic  full_i,       // RX FIFO full
    input  logic  empty_i,      // TX FIFO empty
    i2c_phase_if.monitor phase
);
    import i2c_bus_pkg::*;

    localparam int CNT_W = $clog2(`I2C_BYTE_BITS + 1);

    logic             scl_q;
    logic [CNT_W-1:0] rise_cnt;
    logic             in_byte;
    logic             in_ack;

    //------------------------------------------------------------------------
    // SCL edge detect
    //------------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_q <= 1'b1;      // Bus idles high
        end else begin
            scl_q <= i2c_scl_i;
        end
    end

    assign phase.scl_rise = i2c_scl_i & ~scl_q;
    assign phase.scl_fall = ~i2c_scl_i & scl_q;

    //------------------------------------------------------------------------
    // Bit counter and ACK capture
    //------------------------------------------------------------------------
    assign in_byte = (phase.state == ADDRESS) || (phase.state == WRITE_DATA) ||
                     (phase.state == READ_DATA);
    assign in_ack  = (phase.state == READ_ACK) || (phase.state == READ_LATER_ACK);

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rise_cnt <= '0;
        end else if (!in_byte) begin
            rise_cnt <= '0;
        end else if (phase.scl_rise) begin
            rise_cnt <= rise_cnt + 1'b1;
        end
    end

    assign phase.byte_done = (rise_cnt == CNT_W'(`I2C_BYTE_BITS));

    // Slave drives SDA low while SCL is high for an ACK
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            phase.ack_to_read  <= 1'b0;
            phase.ack_to_write <= 1'b0;
        end else if (!in_ack) begin
            phase.ack_to_read  <= 1'b0;
            phase.ack_to_write <= 1'b0;
        end else if (phase.scl_rise && !i2c_sda_i) begin
            if (rw_i && !full_i) begin
                phase.ack_to_read  <= 1'b1;
                phase.ack_to_write <= 1'b0;
            end else if (!rw_i && !empty_i) begin
                phase.ack_to_read  <= 1'b0;
                phase.ack_to_write <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/i2c_phase_sequencer.sv
`timescale 1ns/100ps

module i2c_phase_sequencer (
    input  logic  i2c_core_clk_i,
    input  logic  reset_ni,
    input  logic  enable_i,         // Start a transfer
    input  logic  repeat_start_i,
    input  logic  full_i,
    input  logic  empty_i,
    input  logic  i2c_scl_i,
    i2c_phase_if.sequencer phase
);
    import i2c_bus_pkg::*;

    logic byte_end;

    // Last bit of a byte is out once SCL drops after the 8th rise
    assign byte_end = phase.byte_done & phase.scl_fall;

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            phase.state <= IDLE;
        end else begin
            phase.state <= phase.next_state;
        end
    end

    //------------------------------------------------------------------------
    // Next-state logic
    //------------------------------------------------------------------------
    always_comb begin
        phase.next_state = phase.state;     // Hold by default
        case (phase.state)
            IDLE: begin
                if (enable_i) phase.next_state = START;
            end
            START: begin
                if (!i2c_scl_i) phase.next_state = ADDRESS;
            end
            ADDRESS: begin
                if (byte_end) phase.next_state = READ_ACK;
            end
            READ_ACK: begin
                if (phase.scl_fall) begin
                    if (phase.ack_to_read) begin
                        phase.next_state = READ_DATA;
                    end else if (phase.ack_to_write) begin
                        phase.next_state = WRITE_DATA;
                    end else begin
                        phase.next_state = STOP;    // Address NACK
                    end
                end
            end
            WRITE_DATA: begin
                if (byte_end) phase.next_state = READ_LATER_ACK;
            end
            READ_LATER_ACK: begin
                if (phase.scl_fall) begin
                    if (empty_i || (!phase.ack_to_write && !repeat_start_i)) begin
                        phase.next_state = STOP;
                    end else if (!phase.ack_to_write) begin
                        phase.next_state = REPEAT_START;
                    end else begin
                        phase.next_state = WRITE_DATA;
                    end
                end
            end
            READ_DATA: begin
                if (byte_end) phase.next_state = WRITE_ACK;
            end
            WRITE_ACK: begin
                if (phase.scl_fall) begin
                    if (repeat_start_i) begin
                        phase.next_state = REPEAT_START;
                    end else if (!full_i) begin
                        phase.next_state = READ_DATA;
                    end else begin
                        phase.next_state = STOP;    // RX FIFO full
                    end
                end
            end
            REPEAT_START: begin
                if (phase.scl_rise) phase.next_state = START;
            end
            STOP: begin
                if (phase.scl_rise) phase.next_state = IDLE;
            end
            default: phase.next_state = IDLE;
        endcase
    end

endmodule

// File: verilog/i2c_line_driver.sv
`timescale 1ns/100ps
`include "i2c_master_params.svh"

module i2c_line_driver (
    input  logic                     i2c_core_clk_i,
    input  logic                     reset_ni,
    input  logic                     i2c_scl_i,
    input  logic                     i2c_sda_i,
    input  logic                     full_i,
    i2c_phase_if.driver              phase,
    output i2c_ctrl_pkg::line_ctrl_t line_ctrl_o,
    output logic [3:0]               count_bit_o,   // Datapath bit index, MSB first
    output logic                     r_fifo_en_o,   // TX FIFO read strobe
    output logic                     w_fifo_en_o    // RX FIFO write strobe
);
    import i2c_bus_pkg::*;

    logic bit_step;

    //------------------------------------------------------------------------
    // Line-drive enables
    //------------------------------------------------------------------------
    always_comb begin
        line_ctrl_o = '0;
        if (phase.state != IDLE) begin
            line_ctrl_o.clk_en = 1'b1;
            line_ctrl_o.scl_en = 1'b1;
        end
        case (phase.state)
            START: begin
                line_ctrl_o.sda_low_en = 1'b1;
                line_ctrl_o.sda_en     = 1'b1;
            end
            ADDRESS: begin
                line_ctrl_o.write_addr_en = ~i2c_scl_i;    // Change SDA only while SCL low
                line_ctrl_o.sda_en        = 1'b1;
            end
            WRITE_DATA: begin
                line_ctrl_o.write_data_en = ~i2c_scl_i;
                line_ctrl_o.sda_en        = 1'b1;
            end
            READ_LATER_ACK: line_ctrl_o.sda_low_en = 1'b1;
            READ_DATA:      line_ctrl_o.receive_data_en = i2c_scl_i;
            WRITE_ACK: begin
                line_ctrl_o.sda_low_en = 1'b1;
                line_ctrl_o.sda_en     = ~full_i;  // Release SDA for a NACK when full
            end
            STOP: begin
                line_ctrl_o.sda_low_en = i2c_sda_i;
                line_ctrl_o.sda_en     = 1'b1;
            end
            default: ;
        endcase
    end

    //------------------------------------------------------------------------
    // Bit index
    //------------------------------------------------------------------------
    // Writes step on the rise, reads step on the fall
    always_comb begin
        case (phase.state)
            ADDRESS, WRITE_DATA: bit_step = phase.scl_rise;
            READ_DATA:           bit_step = phase.scl_fall;
            default:             bit_step = 1'b0;
        endcase
    end

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            count_bit_o <= '0;
        end else if (phase.state != ADDRESS && phase.state != WRITE_DATA &&
                     phase.state != READ_DATA) begin
            count_bit_o <= 4'(`I2C_FIRST_BIT);
        end else if (bit_step && count_bit_o != '0) begin
            count_bit_o <= count_bit_o - 1'b1;    // Saturates at bit 0
        end
    end

    //------------------------------------------------------------------------
    // FIFO strobes
    //------------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            r_fifo_en_o <= 1'b0;
            w_fifo_en_o <= 1'b0;
        end else begin
            r_fifo_en_o <= (phase.state == READ_LATER_ACK) && phase.scl_rise;
            // Read byte complete, push it once
            w_fifo_en_o <= (phase.state == READ_DATA) && (phase.next_state == WRITE_ACK);
        end
    end

endmodule

// File: verilog/i2c_master_fsm.sv
`timescale 1ns/100ps

module i2c_master_fsm (
    input  logic       i2c_core_clk_i,
    input  logic       reset_ni,
    input  logic       enable_i,            // Start request
    input  logic       repeat_start_i,      // Repeated START request
    input  logic       rw_i,                // 1 read, 0 write
    input  logic       full_i,              // RX FIFO full
    input  logic       empty_i,             // TX FIFO empty
    input  logic       i2c_sda_i,           // SDA level from the bus
    input  logic       i2c_scl_i,           // SCL level from the bus

    output logic       sda_low_en_o,
    output logic       clk_en_o,
    output logic       write_data_en_o,
    output logic       write_addr_en_o,
    output logic       receive_data_en_o,
    output logic       i2c_sda_en_o,
    output logic       i2c_scl_en_o,
    output logic [3:0] count_bit_o,
    output logic       r_fifo_en_o,
    output logic       w_fifo_en_o
);
    import i2c_ctrl_pkg::*;

    line_ctrl_t line_ctrl;

    i2c_phase_if phase ();

    // Decode
    i2c_bus_monitor u_monitor (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .i2c_sda_i      (i2c_sda_i),
        .rw_i           (rw_i),
        .full_i         (full_i),
        .empty_i        (empty_i),
        .phase          (phase.monitor)
    );

    // Execute
    i2c_phase_sequencer u_sequencer (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .enable_i       (enable_i),
        .repeat_start_i (repeat_start_i),
        .full_i         (full_i),
        .empty_i        (empty_i),
        .i2c_scl_i      (i2c_scl_i),
        .phase          (phase.sequencer)
    );

    // Result
    i2c_line_driver u_driver (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .i2c_sda_i      (i2c_sda_i),
        .full_i         (full_i),
        .phase          (phase.driver),
        .line_ctrl_o    (line_ctrl),
        .count_bit_o    (count_bit_o),
        .r_fifo_en_o    (r_fifo_en_o),
        .w_fifo_en_o    (w_fifo_en_o)
    );

    assign sda_low_en_o      = line_ctrl.sda_low_en;
    assign clk_en_o          = line_ctrl.clk_en;
    assign write_data_en_o   = line_ctrl.write_data_en;
    assign write_addr_en_o   = line_ctrl.write_addr_en;
    assign receive_data_en_o = line_ctrl.receive_data_en;
    assign i2c_sda_en_o      = line_ctrl.sda_en;
    assign i2c_scl_en_o      = line_ctrl.scl_en;

endmodule

// File: verif/i2c_master_fsm_tb.sv
`timescale 1ns/100ps

module i2c_master_fsm_tb;
    import i2c_bus_pkg::*;

    localparam int MAX_VEC      = 256;
    localparam int RESET_CYCLES = 3;
    localparam int TIME_SLACK   = 20;  // Extra cycles allowed past the vectors

    logic        i2c_core_clk = 1'b0;
    logic        reset_n;
    logic        enable, repeat_start, rw, full, empty, sda, scl;
    logic        sda_low_en, clk_en, write_data_en, write_addr_en;
    logic        receive_data_en, sda_en, scl_en;
    logic [3:0]  count_bit;
    logic        r_fifo_en, w_fifo_en;
    logic [27:0] vec_mem [0:MAX_VEC-1];  // {test, inputs, expected outputs}
    logic [27:0] vec;
    logic [3:0]  cur_test;
    i2c_state_e  dut_state;
    int          num_vec;
    int          cycle_cnt   = 0;
    int          cycle_limit = MAX_VEC;
    int          err_cnt     = 0;
    int          check_cnt   = 0;
    int          test_errs   = 0;
    int          test_cnt    = 0;

    i2c_master_fsm dut0 (
        .i2c_core_clk_i    (i2c_core_clk),
        .reset_ni          (reset_n),
        .enable_i          (enable),
        .repeat_start_i    (repeat_start),
        .rw_i              (rw),
        .full_i            (full),
        .empty_i           (empty),
        .i2c_sda_i         (sda),
        .i2c_scl_i         (scl),
        .sda_low_en_o      (sda_low_en),
        .clk_en_o          (clk_en),
        .write_data_en_o   (write_data_en),
        .write_addr_en_o   (write_addr_en),
        .receive_data_en_o (receive_data_en),
        .i2c_sda_en_o      (sda_en),
        .i2c_scl_en_o      (scl_en),
        .count_bit_o       (count_bit),
        .r_fifo_en_o       (r_fifo_en),
        .w_fifo_en_o       (w_fifo_en)
    );

    assign dut_state = dut0.phase.state;  // Only for messages

    always #4 i2c_core_clk = ~i2c_core_clk;

    always @(posedge i2c_core_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //------------------------------------------------------------------------
    // Checking and reporting
    //------------------------------------------------------------------------
    task automatic compare_value(input logic [6:0] got, input logic [6:0] exp,
                                 input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            test_errs++;
            $display("Mismatch at %0t: test %0d, %s is %h, expected %h in state %s",
                     $time, cur_test, what, got, exp, dut_state.name());
        end
    endtask

    task automatic check_outputs(input logic [6:0] exp_en, input logic [3:0] exp_cnt,
                                 input logic [1:0] exp_fifo);
        compare_value({sda_low_en, clk_en, write_data_en, write_addr_en,
                       receive_data_en, sda_en, scl_en}, exp_en, "line enables");
        compare_value({3'b000, count_bit}, {3'b000, exp_cnt}, "count_bit_o");
        compare_value({5'b00000, r_fifo_en, w_fifo_en}, {5'b00000, exp_fifo},
                      "FIFO strobes");
    endtask

    task automatic report_test();
        test_cnt++;
        $display("Test %0d finished with %0d errors", cur_test, test_errs);
        test_errs = 0;
    endtask

    //------------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------------
    initial begin
        enable       = 1'b0;
        repeat_start = 1'b0;
        rw           = 1'b0;
        full         = 1'b0;
        empty        = 1'b0;
        sda          = 1'b1;  // Bus idles high
        scl          = 1'b1;
        reset_n      = 1'b0;
        cur_test     = 4'd1;  // Reset belongs to test 1
        $readmemh("verif/i2c_master_input.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec]) &&
               vec_mem[num_vec][27:24] != 4'd0) begin
            num_vec++;
        end
        cycle_limit = num_vec + RESET_CYCLES + TIME_SLACK;
        if (num_vec == 0) begin
            $display("No vectors could be read from verif/i2c_master_input.txt");
            err_cnt++;
        end

        // All enables and strobes low while reset is held
        repeat (RESET_CYCLES) begin
            @(posedge i2c_core_clk);
            #1;
            check_outputs(7'h00, 4'h0, 2'b00);
        end

        @(negedge i2c_core_clk);
        reset_n = 1'b1;
        for (int i = 0; i < num_vec; i++) begin
            vec = vec_mem[i];
            if (vec[27:24] != cur_test) begin
                report_test();
                cur_test = vec[27:24];
            end
            {enable, repeat_start, rw, full} = vec[23:20];
            {empty, sda, scl}                = vec[18:16];
            @(posedge i2c_core_clk);
            #1;
            check_outputs({vec[15:12], vec[10:8]}, vec[7:4], vec[1:0]);
            @(negedge i2c_core_clk);
        end
        report_test();

        $display("Done: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/i2c_master_input.txt
// One word per clock, 7 hex digits: test, {enable,repeat_start,rw,full}, {0,empty,sda,scl},
// then expected {sda_low,clk,wr_data,wr_addr}, {0,rx_data,sda_en,scl_en}, count_bit, {0,0,r,w}
// Test 1: idle after reset
1030070 1030070
// Test 2: write address and one data byte, TX FIFO empties, STOP
283C370 203C370 2025370
2034360 2025360 2034350 2025350 2034340 2025340 2034330 2025330 2034320 2025320
2034310 2025310 2034300 2025300 2034300 2024100 2014170 2006370
2034360 2026360 2034350 2026350 2034340 2026340 2034330 2026330 2034320 2026320
2034310 2026310 2034300 2026300 2034300 202C100 201C172 2044370 206C370 2070070 2030070
// Test 3: read one byte, master ACK, RX FIFO full ends in STOP
3A3C370 3225370
3234360 3225360 3234350 3225350 3234340 3225340 3234330 3225330 3234320 3225320
3234310 3225310 3234300 3225300 3234300 3224100 3214170 3204170
3234570 3224160 3234560 3224150 3234550 3224140 3234540 3224130 3234530 3224120
3234520 3224110 3234510 3224100 3234500 322C301 321C370 331C170 3304370 332C370 3230070
// Test 4: address NACK goes to STOP
483C370 4025370
4034360 4025360 4034350 4025350 4034340 4025340 4034330 4025330 4034320 4025320
4034310 4025310 4034300 4025300 4034300 4024100 4034170 402C370 4004370 402C370 4030070
// Test 5: data NACK with repeated START
583C370 5025370
5034360 5025360 5034350 5025350 5034340 5025340 5034330 5025330 5034320 5025320
5034310 5025310 5034300 5025300 5034300 5024100 5014170 5006370
5034360 5026360 5034350 5026350 5034340 5026340 5034330 5026330 5034320 5026320
5034310 5026310 5034300 5026300 5034300 502C100 543C172 5424170 5024170 503C370
// End marker
0000000

// File: verilog.f
+incdir+verilog
verilog/i2c_bus_pkg.sv
verilog/i2c_ctrl_pkg.sv
verilog/i2c_phase_if.sv
verilog/i2c_bus_monitor.sv
verilog/i2c_phase_sequencer.sv
verilog/i2c_line_driver.sv
verilog/i2c_master_fsm.sv
verif/i2c_master_fsm_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module i2c_master_fsm_tb -f verilog.f -o i2c_master_sim \
    && ./obj_dir/i2c_master_sim > sim.log 2>&1 \
    || echo "Build or simulation run did not complete"
cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
